// File: flist.f
+incdir+hdl
hdl/aes_dec_pkg.sv
hdl/aes_key_expand.sv
hdl/aes_inv_round.sv
hdl/aes_dec_stage.sv
hdl/aes_dec_top.sv
tests/aes_dec_assert.sv
tests/aes_dec_tb.sv

// File: Bender.yml
package:
  name: aes_dec

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/aes_dec_pkg.sv
      - hdl/aes_key_expand.sv
      - hdl/aes_inv_round.sv
      - hdl/aes_dec_stage.sv
      - hdl/aes_dec_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/aes_dec_assert.sv
      - tests/aes_dec_tb.sv

// File: tests/aes_dec_tb.sv
`include "aes_dec_consts.svh"

module aes_dec_tb
  import aes_dec_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period = 4;
  localparam int reset_cycles = 16;
  localparam int num_tests = 5;
  // Input slots of all tests with every gap at its longest
  localparam int total_slots = 1 + 40 + 30 * 4 + 5 * 8 + 8 + 10;
  localparam int timeout_cycles = reset_cycles + total_slots + 4 * num_tests + 200;

  logic       clk;
  logic       reset;
  logic       valid_in;
  aes_state_t ciphertext;
  aes_state_t key;
  logic       valid_out;
  aes_state_t plaintext;

  integer     seed = 88573;
  int         errors = 0;
  int         tests_failed = 0;
  int         cyc = 0;
  int         out_count = 0;
  int         err_mark;
  int         out_mark;
  aes_state_t exp_q[$];
  int         sent_q[$];

  aes_dec_top dut0 (
    .clk       (clk),
    .reset     (reset),
    .valid_in  (valid_in),
    .ciphertext(ciphertext),
    .key       (key),
    .valid_out (valid_out),
    .plaintext (plaintext)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic aes_byte_t mul2(aes_byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // Forward key schedule with the cipher key as entry 0
  function automatic aes_round_keys_t expand_key(aes_state_t k);
    aes_word_t       w [44];
    aes_word_t       t;
    aes_byte_t       rc;
    aes_round_keys_t rk;
    rc = 8'h01;
    for (int i = 0; i < 44; i++) begin
      if (i < 4) begin
        w[i] = k[127 - 32*i -: 32];
      end else begin
        t = w[i-1];
        if (i % 4 == 0) begin
          t = {sbox(t[23:16]) ^ rc, sbox(t[15:8]), sbox(t[7:0]), sbox(t[31:24])};
          rc = mul2(rc);
        end
        w[i] = w[i-4] ^ t;
      end
    end
    for (int r = 0; r < 11; r++) begin
      rk[r] = {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
    end
    return rk;
  endfunction

  // SubBytes and ShiftRows together, then MixColumns and AddRoundKey
  function automatic aes_state_t encrypt_round(aes_state_t s, aes_state_t rk, bit mix);
    aes_state_t sh;
    aes_state_t r;
    aes_byte_t  b0;
    aes_byte_t  b1;
    aes_byte_t  b2;
    aes_byte_t  b3;
    for (int c = 0; c < 4; c++) begin
      for (int rw = 0; rw < 4; rw++) begin
        sh[127 - 8*(4*c + rw) -: 8] = sbox(s[127 - 8*(4*((c + rw) % 4) + rw) -: 8]);
      end
    end
    r = sh;
    if (mix) begin
      for (int c = 0; c < 4; c++) begin
        {b0, b1, b2, b3} = sh[127 - 32*c -: 32];
        r[127 - 32*c -: 32] = {
          mul2(b0) ^ mul2(b1) ^ b1 ^ b2 ^ b3,
          b0 ^ mul2(b1) ^ mul2(b2) ^ b2 ^ b3,
          b0 ^ b1 ^ mul2(b2) ^ mul2(b3) ^ b3,
          mul2(b0) ^ b0 ^ b1 ^ b2 ^ mul2(b3)
        };
      end
    end
    return r ^ rk;
  endfunction

  function automatic aes_state_t aes_encrypt_ref(aes_state_t pt, aes_state_t k);
    aes_round_keys_t rk;
    aes_state_t      s;
    rk = expand_key(k);
    s = pt ^ rk[0];
    for (int r = 1; r <= 10; r++) begin
      s = encrypt_round(s, rk[r], r != 10);
    end
    return s;
  endfunction

  function automatic aes_state_t random_block();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  task automatic check_value(input string what, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s: got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic send_block(input aes_state_t ct, input aes_state_t k, input aes_state_t pt);
    @(negedge clk);
    valid_in = 1'b1;
    ciphertext = ct;
    key = k;
    exp_q.push_back(pt);
    sent_q.push_back(cyc);
  endtask

  task automatic send_random();
    aes_state_t k;
    aes_state_t pt;
    k = random_block();
    pt = random_block();
    send_block(aes_encrypt_ref(pt, k), k, pt);
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    valid_in = 1'b0;
  endtask

  task automatic drain();
    idle_cycle();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic begin_test();
    err_mark = errors;
    out_mark = out_count;
  endtask

  task automatic end_test(input string name, input int expected_out);
    check_value({name, ": output count"}, out_count - out_mark, expected_out);
    if (errors != err_mark) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_mark);
    end else begin
      $display("test %s: ok, %0d blocks", name, out_count - out_mark);
    end
  endtask

  // In-order scoreboard that also measures latency in edges
  always @(posedge clk) begin
    aes_state_t want;
    int lat;
    if (valid_out) begin
      if (exp_q.size() == 0) begin
        $display("Error at %0t ns: valid_out was high with no block pending", $time);
        errors++;
      end else begin
        want = exp_q.pop_front();
        lat = cyc - sent_q.pop_front();
        out_count++;
        check_value("plaintext", plaintext, want);
        check_value("latency in cycles", lat, `AES_NUM_STAGES);
      end
    end
    cyc++;
  end

  initial begin
    int gap;
    int dropped;
    reset = 1'b1;
    valid_in = 1'b0;
    ciphertext = '0;
    key = '0;
    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;

    begin_test();
    check_value("reference ciphertext",
                aes_encrypt_ref(128'h00112233445566778899aabbccddeeff,
                                128'h000102030405060708090a0b0c0d0e0f),
                128'h69c4e0d86a7b0430d8cdb78070b4c55a);
    send_block(128'h69c4e0d86a7b0430d8cdb78070b4c55a, 128'h000102030405060708090a0b0c0d0e0f,
               128'h00112233445566778899aabbccddeeff);
    drain();
    end_test("known vector", 1);

    begin_test();
    repeat (40) send_random();
    drain();
    end_test("back-to-back", 40);

    begin_test();
    for (int i = 0; i < 30; i++) begin
      gap = $random(seed) & 3;
      repeat (gap) idle_cycle();
      send_random();
    end
    drain();
    end_test("gapped input", 30);

    begin_test();
    repeat (5) begin
      send_random();
      drain();
    end
    end_test("fixed latency", 5);

    begin_test();
    repeat (8) send_random();
    @(negedge clk);
    reset = 1'b1;
    valid_in = 1'b0;
    // The edge in between still delivers one finished block
    @(negedge clk);
    // Blocks from the last three input edges are still in the pipeline
    dropped = exp_q.size();
    check_value("blocks dropped by reset", dropped, `AES_NUM_STAGES - 1);
    exp_q.delete();
    sent_q.delete();
    repeat (3) begin
      check_value("valid_out in reset", valid_out, 0);
      @(negedge clk);
    end
    reset = 1'b0;
    repeat (4) begin
      @(negedge clk);
      check_value("valid_out after reset", valid_out, 0);
    end
    repeat (10) send_random();
    drain();
    end_test("reset mid-stream", 8 - (`AES_NUM_STAGES - 1) + 10);

    $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
             num_tests, tests_failed, errors, dut0.u_checker.fail_count);
    if (errors == 0 && tests_failed == 0 && dut0.u_checker.fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    #(timeout_cycles * clk_period);
    $display("Timeout: the run did not finish within %0d clock cycles", timeout_cycles);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: tests/aes_dec_assert.sv
`include "aes_dec_consts.svh"

module aes_dec_assert
  import aes_dec_pkg::*;
(
  input logic       clk,
  input logic       reset,
  input logic       valid_in,
  input logic       valid_out,
  input aes_state_t plaintext
);

  timeunit 1ns;
  timeprecision 1ps;

  int         fail_count = 0;
  logic       armed = 1'b0;
  logic [2:0] since_reset = 3'd0;

  // Clean edges since the last reset, saturating at the pipeline depth
  always @(posedge clk) begin
    if (reset) begin
      armed <= 1'b1;
      since_reset <= 3'd0;
    end else if (since_reset < `AES_NUM_STAGES) begin
      since_reset <= since_reset + 3'd1;
    end
  end

  quiet_after_reset: assert property (
    @(posedge clk) armed && since_reset < `AES_NUM_STAGES |-> !valid_out
  ) else begin
    $error("valid_out high while the pipeline refills after reset");
    fail_count++;
  end

  fixed_latency: assert property (
    @(posedge clk) disable iff (reset)
    since_reset == `AES_NUM_STAGES |-> valid_out == $past(valid_in, `AES_NUM_STAGES)
  ) else begin
    $error("valid_out does not follow valid_in by the pipeline depth");
    fail_count++;
  end

  known_data: assert property (
    @(posedge clk) disable iff (reset) valid_out |-> !$isunknown(plaintext)
  ) else begin
    $error("plaintext has unknown bits while valid_out is high");
    fail_count++;
  end

endmodule

bind aes_dec_top aes_dec_assert u_checker (
  .clk      (clk),
  .reset    (reset),
  .valid_in (valid_in),
  .valid_out(valid_out),
  .plaintext(plaintext)
);

// File: hdl/aes_dec_top.sv
`include "aes_dec_consts.svh"

module aes_dec_top
  import aes_dec_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       valid_in,
  input  aes_state_t ciphertext,
  input  aes_state_t key,
  output logic       valid_out,
  output aes_state_t plaintext
);

  aes_round_keys_t round_keys;

  logic            s0_valid;
  aes_state_t      s0_state;
  aes_round_keys_t s0_keys;
  logic            s1_valid;
  aes_state_t      s1_state;
  aes_round_keys_t s1_keys;
  logic            s2_valid;
  aes_state_t      s2_state;
  aes_round_keys_t s2_keys;

  aes_key_expand u_key_expand (
    .key       (key),
    .round_keys(round_keys)
  );

  // Rounds 9 to 7 after the initial key add
  aes_dec_stage #(
    .first_round    (`AES_NUM_ROUNDS - 1),
    .num_rounds     (`AES_ROUNDS_PER_STAGE),
    .add_initial_key(1'b1)
  ) stage0 (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_in),
    .state_in (ciphertext),
    .keys_in  (round_keys),
    .valid_out(s0_valid),
    .state_out(s0_state),
    .keys_out (s0_keys)
  );

  aes_dec_stage #(
    .first_round    (`AES_NUM_ROUNDS - 1 - `AES_ROUNDS_PER_STAGE),
    .num_rounds     (`AES_ROUNDS_PER_STAGE),
    .add_initial_key(1'b0)
  ) stage1 (
    .clk      (clk),
    .reset    (reset),
    .valid_in (s0_valid),
    .state_in (s0_state),
    .keys_in  (s0_keys),
    .valid_out(s1_valid),
    .state_out(s1_state),
    .keys_out (s1_keys)
  );

  aes_dec_stage #(
    .first_round    (`AES_NUM_ROUNDS - 1 - 2 * `AES_ROUNDS_PER_STAGE),
    .num_rounds     (`AES_ROUNDS_PER_STAGE),
    .add_initial_key(1'b0)
  ) stage2 (
    .clk      (clk),
    .reset    (reset),
    .valid_in (s1_valid),
    .state_in (s1_state),
    .keys_in  (s1_keys),
    .valid_out(s2_valid),
    .state_out(s2_state),
    .keys_out (s2_keys)
  );

  // Final round only
  aes_dec_stage #(
    .first_round    (0),
    .num_rounds     (`AES_NUM_ROUNDS - (`AES_NUM_STAGES - 1) * `AES_ROUNDS_PER_STAGE),
    .add_initial_key(1'b0)
  ) stage3 (
    .clk      (clk),
    .reset    (reset),
    .valid_in (s2_valid),
    .state_in (s2_state),
    .keys_in  (s2_keys),
    .valid_out(valid_out),
    .state_out(plaintext),
    .keys_out ()
  );

endmodule

// File: hdl/aes_dec_stage.sv
`include "aes_dec_consts.svh"

module aes_dec_stage
  import aes_dec_pkg::*;
#(
  parameter int first_round     = 9,
  parameter int num_rounds      = 3,
  parameter bit add_initial_key = 1'b0
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            valid_in,
  input  aes_state_t      state_in,
  input  aes_round_keys_t keys_in,
  output logic            valid_out,
  output aes_state_t      state_out,
  output aes_round_keys_t keys_out
);

  aes_state_t chain [num_rounds+1];

  // Initial AddRoundKey with the last round key
  generate
    if (add_initial_key) begin : g_init_key
      assign chain[0] = state_in ^ keys_in[`AES_NUM_ROUNDS];
    end else begin : g_no_init_key
      assign chain[0] = state_in;
    end
  endgenerate

  // Rounds run downward from first_round
  generate
    for (genvar i = 0; i < num_rounds; i++) begin : g_round
      aes_inv_round #(
        .round_idx(first_round - i)
      ) u_round (
        .state_in  (chain[i]),
        .round_keys(keys_in),
        .state_out (chain[i+1])
      );
    end
  endgenerate

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= valid_in;
    end
  end

  // Keys travel with their block so every stage can hold a different key
  always_ff @(posedge clk) begin
    state_out <= chain[num_rounds];
    keys_out  <= keys_in;
  end

endmodule

// File: hdl/aes_inv_round.sv
`include "aes_dec_consts.svh"

module aes_inv_round
  import aes_dec_pkg::*;
#(
  parameter int round_idx = 0
) (
  input  aes_state_t      state_in,
  input  aes_round_keys_t round_keys,
  output aes_state_t      state_out
);

  localparam int num_bytes = `AES_BLOCK_BITS / `AES_BYTE_BITS;

  aes_state_t shifted;
  aes_state_t subbed;
  aes_state_t keyed;

  assign shifted = inv_shift_rows(state_in);

  always_comb begin
    for (int i = 0; i < num_bytes; i++) begin
      subbed[i*`AES_BYTE_BITS +: `AES_BYTE_BITS] =
        inv_sbox(shifted[i*`AES_BYTE_BITS +: `AES_BYTE_BITS]);
    end
  end

  assign keyed = subbed ^ round_keys[round_idx];

  // Last round of decryption skips InvMixColumns
  generate
    if (round_idx == 0) begin : g_final
      assign state_out = keyed;
    end else begin : g_mix
      assign state_out = inv_mix_columns(keyed);
    end
  endgenerate

endmodule

// File: hdl/aes_key_expand.sv
`include "aes_dec_consts.svh"

module aes_key_expand
  import aes_dec_pkg::*;
(
  input  aes_state_t      key,
  output aes_round_keys_t round_keys
);

  localparam int num_words = 4 * (`AES_NUM_ROUNDS + 1);

  aes_word_t w [num_words];

  always_comb begin : key_sched
    aes_word_t tmp;
    aes_byte_t rcon;
    rcon = 8'h01;
    for (int i = 0; i < 4; i++) begin
      w[i] = key[`AES_BLOCK_BITS-1 - `AES_WORD_BITS*i -: `AES_WORD_BITS];
    end
    for (int i = 4; i < num_words; i++) begin
      tmp = w[i-1];
      // RotWord, SubWord and the round constant
      if (i % 4 == 0) begin
        tmp = {sbox(tmp[23:16]), sbox(tmp[15:8]), sbox(tmp[7:0]), sbox(tmp[31:24])};
        tmp = tmp ^ {rcon, 24'h000000};
        rcon = xtime(rcon);
      end
      w[i] = w[i-4] ^ tmp;
    end
    for (int r = 0; r <= `AES_NUM_ROUNDS; r++) begin
      round_keys[r] = {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
    end
  end

endmodule

// File: hdl/aes_dec_pkg.sv
`include "aes_dec_consts.svh"

package aes_dec_pkg;

  typedef logic [`AES_BYTE_BITS-1:0] aes_byte_t;
  typedef logic [`AES_WORD_BITS-1:0] aes_word_t;

  // Column 0 in the top word, row 0 in the top byte of each column
  typedef logic [`AES_BLOCK_BITS-1:0] aes_state_t;

  // Indexed by round number, entry 0 is the cipher key
  typedef aes_state_t [`AES_NUM_ROUNDS:0] aes_round_keys_t;

  // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
  function automatic aes_byte_t xtime(aes_byte_t b);
    return {b[6:0], 1'b0} ^ (8'h1b & {8{b[7]}});
  endfunction

  function automatic aes_byte_t gf_mul(aes_byte_t a, aes_byte_t b);
    aes_byte_t acc;
    aes_byte_t sh;
    acc = '0;
    sh = a;
    for (int i = 0; i < `AES_BYTE_BITS; i++) begin
      if (b[i]) begin
        acc = acc ^ sh;
      end
      sh = xtime(sh);
    end
    return acc;
  endfunction

  // a^254, which maps 0 to 0
  function automatic aes_byte_t gf_inv(aes_byte_t a);
    aes_byte_t sq;
    aes_byte_t acc;
    acc = 8'h01;
    sq = a;
    for (int i = 1; i < `AES_BYTE_BITS; i++) begin
      sq = gf_mul(sq, sq);
      acc = gf_mul(acc, sq);
    end
    return acc;
  endfunction

  // Inverse followed by the affine map
  function automatic aes_byte_t sbox(aes_byte_t a);
    aes_byte_t x;
    x = gf_inv(a);
    return x ^ {x[6:0], x[7]} ^ {x[5:0], x[7:6]} ^ {x[4:0], x[7:5]} ^
           {x[3:0], x[7:4]} ^ 8'h63;
  endfunction

  // Inverse affine map first, then the field inverse
  function automatic aes_byte_t inv_sbox(aes_byte_t a);
    aes_byte_t y;
    y = {a[6:0], a[7]} ^ {a[4:0], a[7:5]} ^ {a[1:0], a[7:2]} ^ 8'h05;
    return gf_inv(y);
  endfunction

  // Row r rotates right by r columns
  function automatic aes_state_t inv_shift_rows(aes_state_t s);
    aes_state_t r;
    int src;
    r = '0;
    for (int c = 0; c < 4; c++) begin
      for (int rw = 0; rw < 4; rw++) begin
        src = 4 * ((c - rw + 4) % 4) + rw;
        r[`AES_BLOCK_BITS-1 - `AES_BYTE_BITS*(4*c + rw) -: `AES_BYTE_BITS] =
          s[`AES_BLOCK_BITS-1 - `AES_BYTE_BITS*src -: `AES_BYTE_BITS];
      end
    end
    return r;
  endfunction

  function automatic aes_state_t inv_mix_columns(aes_state_t s);
    aes_state_t r;
    aes_word_t col;
    aes_byte_t b0;
    aes_byte_t b1;
    aes_byte_t b2;
    aes_byte_t b3;
    r = '0;
    for (int c = 0; c < 4; c++) begin
      col = s[`AES_BLOCK_BITS-1 - `AES_WORD_BITS*c -: `AES_WORD_BITS];
      {b0, b1, b2, b3} = col;
      r[`AES_BLOCK_BITS-1 - `AES_WORD_BITS*c -: `AES_WORD_BITS] = {
        gf_mul(b0, 8'h0e) ^ gf_mul(b1, 8'h0b) ^ gf_mul(b2, 8'h0d) ^ gf_mul(b3, 8'h09),
        gf_mul(b0, 8'h09) ^ gf_mul(b1, 8'h0e) ^ gf_mul(b2, 8'h0b) ^ gf_mul(b3, 8'h0d),
        gf_mul(b0, 8'h0d) ^ gf_mul(b1, 8'h09) ^ gf_mul(b2, 8'h0e) ^ gf_mul(b3, 8'h0b),
        gf_mul(b0, 8'h0b) ^ gf_mul(b1, 8'h0d) ^ gf_mul(b2, 8'h09) ^ gf_mul(b3, 8'h0e)
      };
    end
    return r;
  endfunction

endpackage

// File: hdl/aes_dec_consts.svh
`ifndef AES_DEC_CONSTS_SVH
`define AES_DEC_CONSTS_SVH

// Block width, also the AES-128 key width
`define AES_BLOCK_BITS 128

// Key schedule word and state column
`define AES_WORD_BITS 32

`define AES_BYTE_BITS 8

// Rounds of the AES-128 cipher
`define AES_NUM_ROUNDS 10

// Register stages between ciphertext and plaintext
`define AES_NUM_STAGES 4

// Stages 0 to 2 hold this many rounds, the last stage holds the rest
`define AES_ROUNDS_PER_STAGE 3

`endif
